// File: pmp_defines.svh
// PMP configuration constants for region count, CSR map and granularity
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// Region count and the pmpcfg registers that hold four cfg bytes each
`define PMP_NUM_REGIONS 8
`define PMP_NUM_CFG_REGS 2

// M-mode CSR addresses
`define PMP_CSR_PMPCFG0 12'h3A0
`define PMP_CSR_PMPADDR0 12'h3B0
`define PMP_CSR_MSECCFG 12'h747
`define PMP_CSR_MSECCFGH 12'h757

// Rule locking bypass inside mseccfg
`define PMP_MSECCFG_RLB_BIT 2

// G as in the privileged spec, region grain is 2^(G+2) bytes
`define PMP_GRANULARITY_DEFAULT 0

`endif

// File: pmp_pkg.sv
// PMP types shared by the CSR file, the cfg legalizer and the access checker
`include "pmp_defines.svh"

package pmp_pkg;

  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    ACC_EXEC  = 2'b00,
    ACC_READ  = 2'b01,
    ACC_WRITE = 2'b10
  } pmp_acc_e;

  localparam int REGION_IDX_W = $clog2(`PMP_NUM_REGIONS);

  // One cfg byte, lock in bit 7
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    priv_e       mode;
    logic [11:0] addr;
    logic [31:0] wdata;
  } pmp_csr_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        illegal;
  } pmp_csr_rsp_t;

  // Stored values, addr in word units
  typedef struct packed {
    pmp_cfg_t [`PMP_NUM_REGIONS-1:0]        cfg;
    logic     [`PMP_NUM_REGIONS-1:0][31:0] addr;
  } pmp_state_t;

  typedef struct packed {
    logic        valid;
    pmp_acc_e    acc;
    priv_e       mode;
    logic [31:0] addr;
  } pmp_req_t;

  typedef struct packed {
    logic                    valid;
    logic                    allowed;
    logic [REGION_IDX_W-1:0] region;
  } pmp_rsp_t;

  // Low pmpaddr bits below the grain, G ones
  function automatic logic [31:0] gran_low_mask(int g);
    return (32'h1 << g) - 32'h1;
  endfunction

  // NAPOT bits that read as ones, G-1 of them for G>=2
  function automatic logic [31:0] gran_napot_ones(int g);
    return (g >= 2) ? gran_low_mask(g - 1) : 32'h0;
  endfunction

endpackage

// File: pmp_cfg_legalize.sv
// PMP cfg byte legalizer, turns an attempted write into the stored value
`timescale 1ns/1ns
`include "pmp_defines.svh"

module pmp_cfg_legalize #(
  parameter int PMP_GRANULARITY = `PMP_GRANULARITY_DEFAULT
) (
  input  pmp_pkg::pmp_cfg_t cfg_old_i,
  input  pmp_pkg::pmp_cfg_t cfg_attempt_i,
  input  logic              rlb_i,
  output pmp_pkg::pmp_cfg_t cfg_new_o
);

  logic rw_reserved;
  logic na4_refused;

  // R=0 W=1 is a reserved combination
  assign rw_reserved = !cfg_attempt_i.read && cfg_attempt_i.write;

  // NA4 only exists for a 4-byte grain
  assign na4_refused = (PMP_GRANULARITY >= 1) && (cfg_attempt_i.mode == pmp_pkg::PMP_NA4);

  always_comb begin
    cfg_new_o = cfg_attempt_i;

    if (rw_reserved) begin
      cfg_new_o.read  = cfg_old_i.read;
      cfg_new_o.write = cfg_old_i.write;
      cfg_new_o.exec  = cfg_old_i.exec;
    end

    if (na4_refused) begin
      cfg_new_o.mode = cfg_old_i.mode;
    end

    // Locked byte is frozen unless RLB
    if (cfg_old_i.lock && !rlb_i) begin
      cfg_new_o = cfg_old_i;
    end

    cfg_new_o.zero = 2'b00;
  end

  // Holds only while the stored byte was itself legal
  a_no_rw01: assert final ($isunknown(cfg_new_o) || cfg_new_o.read || !cfg_new_o.write)
    else $error("legalized cfg carries reserved RW=01");

endmodule

// File: pmp_csr_regs.sv
// PMP CSR file with cfg legalization, lock and RLB rules and shaped readback
`timescale 1ns/1ns
`include "pmp_defines.svh"

module pmp_csr_regs #(
  parameter int PMP_GRANULARITY = `PMP_GRANULARITY_DEFAULT
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  pmp_pkg::pmp_csr_req_t csr_req_i,
  output pmp_pkg::pmp_csr_rsp_t csr_rsp_o,
  output pmp_pkg::pmp_state_t   state_o
);

  localparam int NR = `PMP_NUM_REGIONS;
  localparam logic [31:0] NAPOT_ONES = pmp_pkg::gran_napot_ones(PMP_GRANULARITY);
  localparam logic [31:0] LOW_ZEROS = pmp_pkg::gran_low_mask(PMP_GRANULARITY);

  pmp_pkg::pmp_cfg_t [NR-1:0]        cfg_q;
  pmp_pkg::pmp_cfg_t [NR-1:0]        cfg_new;
  logic              [NR-1:0][31:0] addr_q;
  logic              [NR-1:0][31:0] addr_rd;
  logic                             rlb_q;

  logic [11:0]   cfg_off;
  logic [11:0]   addr_off;
  logic          cfg_hit;
  logic          addr_hit;
  logic          mseccfg_hit;
  logic          mseccfgh_hit;
  logic          illegal;
  logic          wr_en;
  logic [NR-1:0] lock_vec;
  logic [NR-1:0] addr_locked;
  logic [NR-1:0] cfg_wr;
  logic [NR-1:0] addr_wr;
  logic          rlb_wdata;
  logic          rlb_wr;
  logic [31:0]   rdata;

  // Offsets wrap for addresses below the base, so one compare covers the range
  assign cfg_off      = csr_req_i.addr - `PMP_CSR_PMPCFG0;
  assign addr_off     = csr_req_i.addr - `PMP_CSR_PMPADDR0;
  assign cfg_hit      = cfg_off < 12'(`PMP_NUM_CFG_REGS);
  assign addr_hit     = addr_off < 12'(NR);
  assign mseccfg_hit  = csr_req_i.addr == `PMP_CSR_MSECCFG;
  assign mseccfgh_hit = csr_req_i.addr == `PMP_CSR_MSECCFGH;

  // Anything but M mode is refused
  assign illegal = csr_req_i.valid &&
                   ((csr_req_i.mode != pmp_pkg::PRIV_M) ||
                    !(cfg_hit || addr_hit || mseccfg_hit || mseccfgh_hit));
  assign wr_en = csr_req_i.valid && csr_req_i.we && !illegal;

  for (genvar i = 0; i < NR; i++) begin : gen_region
    pmp_cfg_legalize #(
      .PMP_GRANULARITY(PMP_GRANULARITY)
    ) u_legalize (
      .cfg_old_i    (cfg_q[i]),
      .cfg_attempt_i(pmp_pkg::pmp_cfg_t'(csr_req_i.wdata[8*(i%4) +: 8])),
      .rlb_i        (rlb_q),
      .cfg_new_o    (cfg_new[i])
    );

    assign lock_vec[i] = cfg_q[i].lock;

    // A locked TOR entry above also guards this address
    if (i < NR - 1) begin : gen_tor_guard
      assign addr_locked[i] = cfg_q[i].lock ||
                              (cfg_q[i+1].lock && (cfg_q[i+1].mode == pmp_pkg::PMP_TOR));
    end else begin : gen_last
      assign addr_locked[i] = cfg_q[i].lock;
    end

    assign cfg_wr[i]  = wr_en && (cfg_off == 12'(i / 4));
    assign addr_wr[i] = wr_en && (addr_off == 12'(i)) && (!addr_locked[i] || rlb_q);

    assign addr_rd[i] = (cfg_q[i].mode == pmp_pkg::PMP_NAPOT) ? (addr_q[i] | NAPOT_ONES) :
                        (cfg_q[i].mode inside {pmp_pkg::PMP_OFF, pmp_pkg::PMP_TOR}) ?
                        (addr_q[i] & ~LOW_ZEROS) : addr_q[i];

    a_locked_cfg_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cfg_q[i].lock && !rlb_q |=> $stable(cfg_q[i]))
      else $error("locked cfg %0d changed without RLB", i);
  end

  // Setting RLB is refused once something is locked
  assign rlb_wdata = csr_req_i.wdata[`PMP_MSECCFG_RLB_BIT];
  assign rlb_wr    = wr_en && mseccfg_hit && !(rlb_wdata && !rlb_q && (|lock_vec));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else begin
      for (int i = 0; i < NR; i++) begin
        if (cfg_wr[i]) begin
          cfg_q[i] <= cfg_new[i];
        end
        if (addr_wr[i]) begin
          addr_q[i] <= csr_req_i.wdata;
        end
      end
      if (rlb_wr) begin
        rlb_q <= rlb_wdata;
      end
    end
  end

  // Readback from current state, mseccfgh stays zero
  always_comb begin
    rdata = '0;
    for (int r = 0; r < `PMP_NUM_CFG_REGS; r++) begin
      if (cfg_off == 12'(r)) begin
        rdata = cfg_q[4*r +: 4];
      end
    end
    for (int i = 0; i < NR; i++) begin
      if (addr_off == 12'(i)) begin
        rdata = addr_rd[i];
      end
    end
    if (mseccfg_hit) begin
      rdata = 32'(rlb_q) << `PMP_MSECCFG_RLB_BIT;
    end
  end

  assign csr_rsp_o.rdata   = illegal ? '0 : rdata;
  assign csr_rsp_o.illegal = illegal;

  assign state_o.cfg  = cfg_q;
  assign state_o.addr = addr_q;

  a_mseccfgh_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_req_i.valid && mseccfgh_hit |-> csr_rsp_o.rdata == '0)
    else $error("mseccfgh read is not zero");

  a_illegal_no_change: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_rsp_o.illegal |=> $stable(cfg_q) && $stable(addr_q) && $stable(rlb_q))
    else $error("illegal CSR access changed PMP state");

endmodule

// File: pmp_access_check.sv
// PMP access checker with region match, priority select and registered result
`timescale 1ns/1ns
`include "pmp_defines.svh"

module pmp_access_check #(
  parameter int PMP_GRANULARITY = `PMP_GRANULARITY_DEFAULT
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  pmp_pkg::pmp_state_t state_i,
  input  pmp_pkg::pmp_req_t   req_i,
  output pmp_pkg::pmp_rsp_t   rsp_o
);

  localparam int NR = `PMP_NUM_REGIONS;
  localparam logic [31:0] NAPOT_ONES = pmp_pkg::gran_napot_ones(PMP_GRANULARITY);
  localparam logic [31:0] LOW_ZEROS = pmp_pkg::gran_low_mask(PMP_GRANULARITY);

  logic [31:0]                         word_addr;
  logic [NR-1:0]                       match;
  logic                                hit;
  logic [pmp_pkg::REGION_IDX_W-1:0]    hit_idx;
  pmp_pkg::pmp_cfg_t                   hit_cfg;
  logic                                perm;
  logic                                allowed;
  logic                                rsp_valid_q;
  logic                                allowed_q;
  logic [pmp_pkg::REGION_IDX_W-1:0]    region_q;

  // pmpaddr holds bits 33:2 of the byte address
  assign word_addr = {2'b00, req_i.addr[31:2]};

  for (genvar i = 0; i < NR; i++) begin : gen_match
    logic [31:0] tor_lo;
    logic [31:0] tor_hi;
    logic [31:0] napot_addr;
    logic [31:0] napot_mask;
    logic        region_match;

    // TOR bounds snap to the grain
    if (i == 0) begin : gen_lo_zero
      assign tor_lo = '0;
    end else begin : gen_lo_prev
      assign tor_lo = state_i.addr[i-1] & ~LOW_ZEROS;
    end
    assign tor_hi = state_i.addr[i] & ~LOW_ZEROS;

    // Trailing ones plus the next zero give the size bits
    assign napot_addr = state_i.addr[i] | NAPOT_ONES;
    assign napot_mask = ~(napot_addr ^ (napot_addr + 32'h1));

    always_comb begin
      case (state_i.cfg[i].mode)
        pmp_pkg::PMP_TOR:   region_match = (word_addr >= tor_lo) && (word_addr < tor_hi);
        pmp_pkg::PMP_NA4:   region_match = word_addr == state_i.addr[i];
        pmp_pkg::PMP_NAPOT: region_match = (word_addr & napot_mask) == (napot_addr & napot_mask);
        default:            region_match = 1'b0;
      endcase
    end

    assign match[i] = region_match;
  end

  // Lowest index wins, so scan downwards
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NR - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = pmp_pkg::REGION_IDX_W'(i);
      end
    end
  end

  assign hit_cfg = state_i.cfg[hit_idx];

  always_comb begin
    case (req_i.acc)
      pmp_pkg::ACC_EXEC:  perm = hit_cfg.exec;
      pmp_pkg::ACC_READ:  perm = hit_cfg.read;
      pmp_pkg::ACC_WRITE: perm = hit_cfg.write;
      default:            perm = 1'b0;
    endcase
  end

  // M mode bypasses unlocked entries and defaults to allow on a miss
  assign allowed = hit ? (((req_i.mode == pmp_pkg::PRIV_M) && !hit_cfg.lock) || perm)
                       : (req_i.mode == pmp_pkg::PRIV_M);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      allowed_q <= allowed;
      region_q  <= hit_idx;
    end
  end

  assign rsp_o.valid   = rsp_valid_q;
  assign rsp_o.allowed = allowed_q;
  assign rsp_o.region  = region_q;

  a_rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> rsp_o.valid == $past(req_i.valid))
    else $error("response valid does not follow request by one cycle");

endmodule

// File: pmp_top.sv
// PMP unit top, CSR file feeding the registered access checker
`timescale 1ns/1ns
`include "pmp_defines.svh"

module pmp_top #(
  parameter int PMP_GRANULARITY = `PMP_GRANULARITY_DEFAULT
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  pmp_pkg::pmp_csr_req_t csr_req_i,
  output pmp_pkg::pmp_csr_rsp_t csr_rsp_o,
  input  pmp_pkg::pmp_req_t     req_i,
  output pmp_pkg::pmp_rsp_t     rsp_o
);

  // Stored CSR values, not the readback view
  pmp_pkg::pmp_state_t pmp_state;

  pmp_csr_regs #(
    .PMP_GRANULARITY(PMP_GRANULARITY)
  ) u_csr_regs (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .csr_req_i(csr_req_i),
    .csr_rsp_o(csr_rsp_o),
    .state_o  (pmp_state)
  );

  pmp_access_check #(
    .PMP_GRANULARITY(PMP_GRANULARITY)
  ) u_access_check (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .state_i(pmp_state),
    .req_i  (req_i),
    .rsp_o  (rsp_o)
  );

endmodule

// File: tb_pmp.sv
// Self-checking testbench for the PMP unit with CSR shadow and access reference model
`timescale 1ns/1ns
`include "pmp_defines.svh"

module tb_pmp;

  localparam int G = 0;
  localparam int NR = `PMP_NUM_REGIONS;
  localparam int N_RAND = 40;
  localparam int N_ACC = 48;
  localparam int N_B2B = 32;
  localparam int LOCK_OPS = 20;
  localparam int RLB_OPS = 35;
  localparam int ILLEGAL_OPS = 22;
  localparam int SETUP_OPS = 8;
  localparam int TOTAL_OPS = 2 * N_RAND + LOCK_OPS + RLB_OPS + ILLEGAL_OPS + SETUP_OPS +
                             2 * N_ACC + N_B2B;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 100;

  logic                  clk_i;
  logic                  rst_n_i;
  pmp_pkg::pmp_csr_req_t csr_req;
  pmp_pkg::pmp_csr_rsp_t csr_rsp;
  pmp_pkg::pmp_req_t     req;
  pmp_pkg::pmp_rsp_t     rsp;

  // Shadow copy of the CSRs
  logic [7:0]  sh_cfg [NR];
  logic [31:0] sh_addr [NR];
  logic        sh_rlb;

  // Expected responses in issue order
  logic [33:0] csr_exp_q [$];
  string       csr_name_q [$];
  logic [3:0]  acc_exp_q [$];
  string       acc_name_q [$];

  string       test_name;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          err_at_start;
  int          chk_at_start;
  int          cycle_count;
  logic        acc_due;
  logic [33:0] csr_exp;
  logic [3:0]  acc_exp;
  string       exp_name;
  int          sel;
  logic [11:0] csr_addr;
  logic [31:0] wdata;

  pmp_top #(
    .PMP_GRANULARITY(G)
  ) UUT (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .csr_req_i(csr_req),
    .csr_rsp_o(csr_rsp),
    .req_i    (req),
    .rsp_o    (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Five-step legalization of one cfg byte
  function automatic logic [7:0] ref_cfg_write(input logic [7:0] old_b, input logic [7:0] att,
                                               input logic rlb);
    logic [7:0] nb;
    nb = att;
    // R=0 W=1 is reserved
    if (!att[0] && att[1]) begin
      nb[2:0] = old_b[2:0];
    end
    if (att[4:3] == 2'b10 && G >= 1) begin
      nb[4:3] = old_b[4:3];
    end
    if (old_b[7] && !rlb) begin
      nb = old_b;
    end
    nb[6:5] = 2'b00;
    return nb;
  endfunction

  function automatic logic [31:0] ref_addr_read(input int i);
    logic [31:0] v;
    v = sh_addr[i];
    if (sh_cfg[i][4:3] == 2'b11) begin
      for (int b = 0; b < G - 1; b++) begin
        v[b] = 1'b1;
      end
    end else if (sh_cfg[i][4:3] == 2'b00 || sh_cfg[i][4:3] == 2'b01) begin
      for (int b = 0; b < G; b++) begin
        v[b] = 1'b0;
      end
    end
    return v;
  endfunction

  // Own lock or a locked TOR entry just above
  function automatic logic addr_guarded(input int i);
    logic g;
    g = sh_cfg[i][7];
    if (i < NR - 1) begin
      if (sh_cfg[i+1][7] && sh_cfg[i+1][4:3] == 2'b01) begin
        g = 1'b1;
      end
    end
    return g;
  endfunction

  function automatic logic any_locked();
    logic l;
    l = 1'b0;
    for (int i = 0; i < NR; i++) begin
      l = l | sh_cfg[i][7];
    end
    return l;
  endfunction

  // Expected {allowed, region} for one access
  function automatic logic [3:0] ref_access(input pmp_pkg::pmp_acc_e acc,
                                            input pmp_pkg::priv_e mode, input logic [31:0] a);
    logic [31:0] word;
    logic [31:0] lo;
    logic [31:0] v;
    logic [31:0] gmask;
    logic        hit;
    logic        m;
    logic        perm;
    logic        allowed;
    int          hit_i;
    int          k;
    word = {2'b00, a[31:2]};
    gmask = (32'h1 << G) - 32'h1;
    hit = 1'b0;
    hit_i = 0;
    for (int i = 0; i < NR; i++) begin
      m = 1'b0;
      lo = '0;
      if (i > 0) begin
        lo = sh_addr[i-1] & ~gmask;
      end
      case (sh_cfg[i][4:3])
        2'b01: m = (lo <= word) && (word < (sh_addr[i] & ~gmask));
        2'b10: m = word == sh_addr[i];
        2'b11: begin
          v = ref_addr_read(i);
          k = 0;
          while (k < 32 && v[k]) begin
            k++;
          end
          m = (k >= 31) || ((word >> (k + 1)) == (v >> (k + 1)));
        end
        default: m = 1'b0;
      endcase
      if (m && !hit) begin
        hit = 1'b1;
        hit_i = i;
      end
    end
    if (hit) begin
      case (acc)
        pmp_pkg::ACC_EXEC:  perm = sh_cfg[hit_i][2];
        pmp_pkg::ACC_READ:  perm = sh_cfg[hit_i][0];
        pmp_pkg::ACC_WRITE: perm = sh_cfg[hit_i][1];
        default:            perm = 1'b0;
      endcase
      allowed = ((mode == pmp_pkg::PRIV_M) && !sh_cfg[hit_i][7]) || perm;
    end else begin
      allowed = mode == pmp_pkg::PRIV_M;
    end
    return {allowed, 3'(hit_i)};
  endfunction

  function automatic logic [31:0] pick_addr();
    case ($urandom % 4)
      0:       return 32'h3F8 + (($urandom % 4) << 2) + ($urandom % 4);
      1:       return $urandom % 32'h4000;
      2:       return 32'h2FF0 + ($urandom % 32);
      default: return $urandom;
    endcase
  endfunction

  task automatic note_error(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    errors++;
  endtask

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s: expected %0h, actual %0h", what, exp, act);
    errors++;
  endtask

  // One CSR access with the expectation taken from the shadow before its update
  task automatic csr_op(input pmp_pkg::priv_e mode, input logic we, input logic [11:0] a,
                        input logic [31:0] wd);
    logic        is_cfg;
    logic        is_addr;
    logic        illegal;
    logic [31:0] rd;
    int          idx;
    @(posedge clk_i);
    #1;
    is_cfg = a >= `PMP_CSR_PMPCFG0 && a < `PMP_CSR_PMPCFG0 + `PMP_NUM_CFG_REGS;
    is_addr = a >= `PMP_CSR_PMPADDR0 && a < `PMP_CSR_PMPADDR0 + NR;
    illegal = (mode != pmp_pkg::PRIV_M) ||
              !(is_cfg || is_addr || a == `PMP_CSR_MSECCFG || a == `PMP_CSR_MSECCFGH);
    rd = '0;
    idx = 0;
    if (is_cfg) begin
      idx = a - `PMP_CSR_PMPCFG0;
      for (int k = 0; k < 4; k++) begin
        rd[8*k +: 8] = sh_cfg[4*idx + k];
      end
    end else if (is_addr) begin
      idx = a - `PMP_CSR_PMPADDR0;
      rd = ref_addr_read(idx);
    end else if (a == `PMP_CSR_MSECCFG) begin
      rd[`PMP_MSECCFG_RLB_BIT] = sh_rlb;
    end
    csr_exp_q.push_back({!illegal, illegal, rd});
    csr_name_q.push_back(test_name);
    if (we && !illegal) begin
      if (is_cfg) begin
        for (int k = 0; k < 4; k++) begin
          sh_cfg[4*idx + k] = ref_cfg_write(sh_cfg[4*idx + k], wd[8*k +: 8], sh_rlb);
        end
      end else if (is_addr) begin
        if (!addr_guarded(idx) || sh_rlb) begin
          sh_addr[idx] = wd;
        end
      end else if (a == `PMP_CSR_MSECCFG) begin
        if (!(wd[`PMP_MSECCFG_RLB_BIT] && !sh_rlb && any_locked())) begin
          sh_rlb = wd[`PMP_MSECCFG_RLB_BIT];
        end
      end
    end
    csr_req.valid = 1'b1;
    csr_req.we = we;
    csr_req.mode = mode;
    csr_req.addr = a;
    csr_req.wdata = wd;
    req.valid = 1'b0;
  endtask

  task automatic csr_wr(input logic [11:0] a, input logic [31:0] wd);
    csr_op(pmp_pkg::PRIV_M, 1'b1, a, wd);
  endtask

  task automatic csr_rd(input logic [11:0] a);
    csr_op(pmp_pkg::PRIV_M, 1'b0, a, 32'h0);
  endtask

  task automatic read_all();
    for (int r = 0; r < `PMP_NUM_CFG_REGS; r++) begin
      csr_rd(12'(`PMP_CSR_PMPCFG0 + r));
    end
    for (int i = 0; i < NR; i++) begin
      csr_rd(12'(`PMP_CSR_PMPADDR0 + i));
    end
  endtask

  task automatic acc_op(input pmp_pkg::pmp_acc_e acc, input pmp_pkg::priv_e mode,
                        input logic [31:0] a);
    @(posedge clk_i);
    #1;
    acc_exp_q.push_back(ref_access(acc, mode, a));
    acc_name_q.push_back(test_name);
    req.valid = 1'b1;
    req.acc = acc;
    req.mode = mode;
    req.addr = a;
    csr_req.valid = 1'b0;
  endtask

  task automatic random_acc();
    acc_op(pmp_pkg::pmp_acc_e'($urandom % 3),
           ($urandom % 2) ? pmp_pkg::PRIV_M : pmp_pkg::PRIV_U, pick_addr());
  endtask

  task automatic idle();
    @(posedge clk_i);
    #1;
    csr_req.valid = 1'b0;
    req.valid = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    csr_req = '0;
    req = '0;
    rst_n_i = 1'b0;
    for (int i = 0; i < NR; i++) begin
      sh_cfg[i] = '0;
      sh_addr[i] = '0;
    end
    sh_rlb = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_at_start = errors;
    chk_at_start = checks;
  endtask

  task automatic finish_test();
    repeat (3) idle();
    if (csr_exp_q.size() != 0 || acc_exp_q.size() != 0) begin
      note_error("expected responses never arrived");
    end
    tests_run++;
    if (errors != err_at_start) begin
      tests_failed++;
    end
    $display("test %s: %0d checks, %0d errors", test_name, checks - chk_at_start,
             errors - err_at_start);
  endtask

  // Compare at the falling edge away from input changes and clock edges
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      acc_due = 1'b0;
    end else begin
      if (csr_req.valid) begin
        if (csr_exp_q.size() == 0) begin
          note_error("CSR response with nothing expected");
        end else begin
          csr_exp = csr_exp_q.pop_front();
          exp_name = csr_name_q.pop_front();
          checks++;
          if (csr_rsp.illegal !== csr_exp[32]) begin
            fail_value({exp_name, " illegal"}, 32'(csr_exp[32]), 32'(csr_rsp.illegal));
          end
          if (csr_exp[33] && csr_rsp.rdata !== csr_exp[31:0]) begin
            fail_value({exp_name, " rdata"}, csr_exp[31:0], csr_rsp.rdata);
          end
        end
      end
      if (acc_due && rsp.valid !== 1'b1) begin
        note_error("no access response one cycle after the request");
      end else if (!acc_due && rsp.valid !== 1'b0) begin
        note_error("access response without a request");
      end else if (acc_due) begin
        acc_exp = acc_exp_q.pop_front();
        exp_name = acc_name_q.pop_front();
        checks++;
        if ({rsp.allowed, rsp.region} !== acc_exp) begin
          fail_value({exp_name, " access"}, 32'(acc_exp), 32'({rsp.allowed, rsp.region}));
        end
      end
      acc_due = req.valid;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h5947));
    csr_req = '0;
    req = '0;
    rst_n_i = 1'b0;
    acc_due = 1'b0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    apply_reset();

    start_test("csr_random");
    repeat (N_RAND) begin
      sel = $urandom % 10;
      wdata = $urandom;
      if (sel < 2) begin
        csr_addr = 12'(`PMP_CSR_PMPCFG0 + sel);
        wdata = wdata & 32'h7F7F7F7F;
      end else begin
        csr_addr = 12'(`PMP_CSR_PMPADDR0 + sel - 2);
      end
      csr_wr(csr_addr, wdata);
      csr_rd(csr_addr);
    end
    finish_test();

    // Region 5 locked TOR, region 0 locked NA4
    apply_reset();
    start_test("lock");
    csr_wr(`PMP_CSR_PMPADDR0 + 4, 32'h0000_0100);
    csr_wr(`PMP_CSR_PMPADDR0 + 5, 32'h0000_0200);
    csr_wr(`PMP_CSR_PMPCFG0 + 1, 32'h0000_8F00);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0000_0091);
    csr_wr(`PMP_CSR_PMPCFG0 + 1, 32'h1F1F_0F1F);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0000_001F);
    csr_wr(`PMP_CSR_PMPADDR0, 32'h0000_1234);
    csr_wr(`PMP_CSR_PMPADDR0 + 4, 32'h0000_0180);
    csr_wr(`PMP_CSR_PMPADDR0 + 5, 32'h0000_0280);
    csr_wr(`PMP_CSR_PMPADDR0 + 6, 32'h0000_0300);
    read_all();
    finish_test();

    apply_reset();
    start_test("rlb");
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0000_0080);
    csr_wr(`PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_rd(`PMP_CSR_MSECCFG);
    apply_reset();
    csr_wr(`PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_rd(`PMP_CSR_MSECCFG);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0088_0080);
    csr_wr(`PMP_CSR_PMPADDR0 + 1, 32'h0000_0400);
    csr_wr(`PMP_CSR_PMPADDR0, 32'h0000_0040);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h000B_001B);
    read_all();
    // Lock again and drop RLB so the locks hold from here on
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0088_0080);
    csr_wr(`PMP_CSR_MSECCFG, 32'h0000_0000);
    csr_wr(`PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_rd(`PMP_CSR_MSECCFG);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0000_0000);
    csr_wr(`PMP_CSR_PMPADDR0 + 1, 32'h0000_0500);
    read_all();
    finish_test();

    // Without locks a leaked mseccfg write would set RLB
    apply_reset();
    start_test("illegal");
    csr_op(pmp_pkg::PRIV_U, 1'b1, `PMP_CSR_PMPCFG0 + 1, 32'h1F1F_1F1F);
    csr_op(pmp_pkg::PRIV_U, 1'b0, `PMP_CSR_PMPCFG0, 32'h0);
    csr_op(pmp_pkg::PRIV_U, 1'b1, `PMP_CSR_PMPADDR0 + 3, 32'h0000_DEAD);
    csr_op(pmp_pkg::PRIV_U, 1'b1, `PMP_CSR_MSECCFG, 32'h0000_0004);
    csr_op(pmp_pkg::PRIV_M, 1'b1, 12'h3A2, 32'h1F1F_1F1F);
    csr_op(pmp_pkg::PRIV_M, 1'b1, 12'h3B8, 32'h0000_BEEF);
    csr_op(pmp_pkg::PRIV_M, 1'b1, 12'h300, 32'hFFFF_FFFF);
    csr_op(pmp_pkg::PRIV_M, 1'b0, 12'h39F, 32'h0);
    csr_rd(`PMP_CSR_MSECCFGH);
    csr_wr(`PMP_CSR_MSECCFGH, 32'hFFFF_FFFF);
    csr_rd(`PMP_CSR_MSECCFGH);
    read_all();
    csr_rd(`PMP_CSR_MSECCFG);
    finish_test();

    // NA4, locked NAPOT, OFF, TOR, locked TOR, wide NAPOT below them
    apply_reset();
    start_test("access_random");
    csr_wr(`PMP_CSR_PMPADDR0, 32'h0000_0100);
    csr_wr(`PMP_CSR_PMPADDR0 + 1, 32'h0000_05FF);
    csr_wr(`PMP_CSR_PMPADDR0 + 2, 32'h0000_0800);
    csr_wr(`PMP_CSR_PMPADDR0 + 3, 32'h0000_0C00);
    csr_wr(`PMP_CSR_PMPADDR0 + 4, 32'h0000_0E00);
    csr_wr(`PMP_CSR_PMPADDR0 + 5, 32'h0000_07FF);
    csr_wr(`PMP_CSR_PMPCFG0, 32'h0B00_9C11);
    csr_wr(`PMP_CSR_PMPCFG0 + 1, 32'h0000_1F89);
    repeat (N_ACC) begin
      random_acc();
      idle();
    end
    finish_test();

    start_test("back_to_back");
    repeat (N_B2B) begin
      random_acc();
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed, checks,
             errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
pmp_pkg.sv
pmp_cfg_legalize.sv
pmp_csr_regs.sv
pmp_access_check.sv
pmp_top.sv
tb_pmp.sv
